//--- src/vid_pkg.sv
`default_nettype none

package vid_pkg;

    typedef logic [31:0] word_t;        // Bus address or data word
    typedef logic [12:0] coord_t;       // Pixel or line coordinate
    typedef logic [5:0]  pix_div_t;     // Pixel lasts pix_div + 1 clocks

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef enum logic [2:0] {
        cmd_idle    = 3'd0,
        cmd_wr_data = 3'd1,
        cmd_rd_req  = 3'd2,
        cmd_rd_data = 3'd3,
        cmd_wr_req  = 3'd4,
        cmd_wr_resp = 3'd5
    } bus_cmd_t;

    typedef struct packed {
        bus_cmd_t   cmd;
        logic [1:0] len;
        word_t      addr_data;
    } bus_t;

    typedef struct packed {
        logic     en;
        pix_div_t pix_div;
        coord_t   hend;
        coord_t   hsize;
        coord_t   hsync_start;
        coord_t   hsync_end;
        coord_t   vend;
        coord_t   vsize;
        coord_t   vsync_start;
        coord_t   vsync_end;
        word_t    base_addr;
        word_t    line_inc;
    } vid_cfg_t;

    typedef struct packed {
        logic hsync;
        logic hblank;
        logic vsync;
        logic vblank;
    } sync_t;

    // Output levels while the controller is off
    localparam sync_t sync_idle = '{hsync: 1'b0, hblank: 1'b1, vsync: 1'b0, vblank: 1'b1};

    localparam word_t reg_cr      = 32'h0000_0000;
    localparam word_t reg_h1      = 32'h0000_0028;
    localparam word_t reg_h2      = 32'h0000_0030;
    localparam word_t reg_v1      = 32'h0000_0038;
    localparam word_t reg_v2      = 32'h0000_0040;
    localparam word_t reg_base    = 32'h0000_0048;
    localparam word_t reg_lineinc = 32'h0000_0050;

    localparam int         burst_beats    = 4;
    localparam logic [1:0] burst_len_code = 2'b10;  // Four-beat read
    localparam int         burst_bytes    = 16;

    localparam int fifo_depth = 16;
    localparam int fifo_ptr_w = 5;      // Index plus wrap bit

endpackage

`default_nettype wire

//--- src/vid_bus_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module vid_bus_ctrl (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire vid_pkg::bus_t    bus_in,
    input  wire vid_pkg::vid_cfg_t cfg,
    input  wire logic             fetch_line,
    input  wire vid_pkg::coord_t  fetch_y,
    output vid_pkg::bus_t         bus_out,
    output logic                  reg_wr,
    output vid_pkg::word_t        reg_addr,
    output vid_pkg::word_t        reg_data,
    output logic                  push,
    output vid_pkg::pixel_t       push_data
);

    typedef enum logic [2:0] {
        idle,
        wr_resp,
        wr_data,
        rd_req,
        rd_beats
    } state_t;

    state_t          state;
    vid_pkg::word_t  wr_offset;     // Latched register offset
    vid_pkg::word_t  line_addr;     // Start address of the line being fetched
    vid_pkg::coord_t burst_cnt;
    vid_pkg::coord_t burst_total;
    logic [1:0]      beat_cnt;
    logic            fetch_pend;    // Fetch request waiting for a write to finish
    logic            wr_accept;
    logic            start_fetch;
    logic            beat_in;
    logic            last_beat;

    // ceil(hsize / 4) bursts per line
    assign burst_total = vid_pkg::coord_t'((int'(cfg.hsize) + vid_pkg::burst_beats - 1)
                                           / vid_pkg::burst_beats);

    assign wr_accept   = (state == idle) && (bus_in.cmd == vid_pkg::cmd_wr_req);
    assign start_fetch = (state == idle) && !wr_accept && (fetch_pend || fetch_line);
    assign beat_in     = (state == rd_beats) && (bus_in.cmd == vid_pkg::cmd_rd_data);
    assign last_beat   = beat_in && (beat_cnt == 2'(vid_pkg::burst_beats - 1));

    assign reg_wr   = (state == wr_data) && (bus_in.cmd == vid_pkg::cmd_wr_data);
    assign reg_addr = wr_offset;
    assign reg_data = bus_in.addr_data;

    always_comb begin
        bus_out.cmd       = vid_pkg::cmd_idle;
        bus_out.len       = 2'b00;
        bus_out.addr_data = '0;
        case (state)
            wr_resp: bus_out.cmd = vid_pkg::cmd_wr_resp;
            rd_req: begin
                bus_out.cmd       = vid_pkg::cmd_rd_req;
                bus_out.len       = vid_pkg::burst_len_code;
                bus_out.addr_data = line_addr
                                    + vid_pkg::word_t'(burst_cnt) * vid_pkg::burst_bytes;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= idle;
            fetch_pend <= 1'b0;
            burst_cnt  <= '0;
            beat_cnt   <= '0;
            push       <= 1'b0;
        end else begin
            push <= beat_in;            // Beat goes to the FIFO one cycle later
            if (fetch_line) begin
                fetch_pend <= 1'b1;
            end
            case (state)
                idle: begin
                    if (wr_accept) begin
                        state <= wr_resp;
                    end else if (start_fetch) begin
                        fetch_pend <= 1'b0;
                        burst_cnt  <= '0;
                        beat_cnt   <= '0;
                        state      <= (burst_total == '0) ? idle : rd_req;
                    end
                end
                wr_resp: state <= wr_data;
                wr_data: begin
                    if (reg_wr) begin
                        state <= idle;
                    end
                end
                rd_req: state <= rd_beats;
                rd_beats: begin
                    if (last_beat) begin
                        beat_cnt <= '0;
                        if (burst_cnt == burst_total - 1'b1) begin
                            state <= idle;      // Line complete
                        end else begin
                            burst_cnt <= burst_cnt + 1'b1;
                            state     <= rd_req;
                        end
                    end else if (beat_in) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_offset <= bus_in.addr_data;
        end
        if (start_fetch) begin
            line_addr <= cfg.base_addr + cfg.line_inc * vid_pkg::word_t'(fetch_y);
        end
        if (beat_in) begin
            push_data <= vid_pkg::pixel_t'(bus_in.addr_data[23:0]);
        end
    end

endmodule

`default_nettype wire

//--- src/vid_regs.sv
`timescale 1ns/10ps
`default_nettype none

module vid_regs (
    input  wire logic           clk,
    input  wire logic           reset_n,
    input  wire logic           reg_wr,
    input  wire vid_pkg::word_t reg_addr,
    input  wire vid_pkg::word_t reg_data,
    output vid_pkg::vid_cfg_t   cfg
);

    logic geom_wr;

    // Geometry and address registers are locked while the controller runs
    assign geom_wr = reg_wr && !cfg.en;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                vid_pkg::reg_cr: begin
                    cfg.en      <= reg_data[3];
                    cfg.pix_div <= reg_data[9:4];
                end
                vid_pkg::reg_h1: begin
                    if (geom_wr) begin
                        cfg.hend  <= reg_data[12:0];
                        cfg.hsize <= reg_data[25:13];
                    end
                end
                vid_pkg::reg_h2: begin
                    if (geom_wr) begin
                        cfg.hsync_start <= reg_data[25:13];
                        cfg.hsync_end   <= reg_data[12:0];
                    end
                end
                vid_pkg::reg_v1: begin
                    if (geom_wr) begin
                        cfg.vend  <= reg_data[12:0];
                        cfg.vsize <= reg_data[25:13];
                    end
                end
                vid_pkg::reg_v2: begin
                    if (geom_wr) begin
                        cfg.vsync_start <= reg_data[25:13];
                        cfg.vsync_end   <= reg_data[12:0];
                    end
                end
                vid_pkg::reg_base: begin
                    if (geom_wr) begin
                        cfg.base_addr <= reg_data;
                    end
                end
                vid_pkg::reg_lineinc: begin
                    if (geom_wr) begin
                        cfg.line_inc <= reg_data;
                    end
                end
                default: ;                  // Unknown offset
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/vid_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vid_timing (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire vid_pkg::vid_cfg_t cfg,
    output vid_pkg::sync_t         sync,
    output logic                   pixel_tick,
    output logic                   active,
    output logic                   fetch_line,
    output vid_pkg::coord_t        fetch_y
);

    vid_pkg::pix_div_t div_cnt;
    vid_pkg::coord_t   h;
    vid_pkg::coord_t   v;
    vid_pkg::coord_t   h_next;
    vid_pkg::coord_t   v_next;
    vid_pkg::coord_t   y_next;
    logic              en_q;
    logic              pix_end;     // Last clock of the current pixel
    logic              start;
    logic              h_act;
    logic              v_act;

    assign pix_end = (div_cnt == cfg.pix_div);
    assign start   = cfg.en && !en_q;
    assign h_act   = (h < cfg.hsize);
    assign v_act   = (v < cfg.vsize);

    // While disabled the tick runs every clock so the RGB register stays cleared
    assign pixel_tick = !cfg.en || pix_end;
    assign active     = cfg.en && h_act && v_act;

    always_comb begin
        h_next = h;
        v_next = v;
        if (pix_end) begin
            if (h == cfg.hend - 1'b1) begin
                h_next = '0;
                v_next = (v == cfg.vend - 1'b1) ? '0 : v + 1'b1;
            end else begin
                h_next = h + 1'b1;
            end
        end
        y_next = (v_next == cfg.vend - 1'b1) ? '0 : v_next + 1'b1;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_q       <= 1'b0;
            div_cnt    <= '0;
            h          <= '0;
            v          <= '0;
            sync       <= vid_pkg::sync_idle;
            fetch_line <= 1'b0;
            fetch_y    <= '0;
        end else begin
            en_q       <= cfg.en;
            fetch_line <= 1'b0;
            if (!cfg.en) begin
                div_cnt <= '0;
                h       <= cfg.hsize;           // Start point, fetches line 0 first
                v       <= cfg.vend - 1'b1;
                sync    <= vid_pkg::sync_idle;
            end else begin
                div_cnt <= pix_end ? '0 : div_cnt + 1'b1;
                h       <= h_next;
                v       <= v_next;
                if (pix_end) begin
                    sync.hsync  <= (h >= cfg.hsync_start) && (h < cfg.hsync_end);
                    sync.hblank <= !h_act;
                    sync.vsync  <= (v >= cfg.vsync_start) && (v < cfg.vsync_end);
                    sync.vblank <= !v_act;
                end
                // Fetch the next line as the active part of this one ends
                if ((start || (pix_end && h_next == cfg.hsize)) && y_next < cfg.vsize) begin
                    fetch_line <= 1'b1;
                    fetch_y    <= y_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pixel_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_fifo (
    input  wire logic            clk,
    input  wire logic            reset_n,
    input  wire logic            flush,
    input  wire logic            push,
    input  wire logic            pop,
    input  wire vid_pkg::pixel_t push_data,
    output vid_pkg::pixel_t      pop_data,
    output logic                 empty
);

    localparam int msb = vid_pkg::fifo_ptr_w - 1;

    vid_pkg::pixel_t mem [vid_pkg::fifo_depth];
    logic [msb:0]    wr_ptr;
    logic [msb:0]    rd_ptr;
    logic            full;
    logic            wr_en;
    logic            rd_en;

    // Same index with opposite wrap bits means full
    assign full  = (wr_ptr[msb] != rd_ptr[msb]) && (wr_ptr[msb-1:0] == rd_ptr[msb-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign pop_data = mem[rd_ptr[msb-1:0]];    // Show-ahead read

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[msb-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                       // Drop leftovers of the previous line
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pixel_out.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_out (
    input  wire logic            clk,
    input  wire logic            reset_n,
    input  wire logic            pixel_tick,
    input  wire logic            active,
    input  wire logic            empty,
    input  wire vid_pkg::pixel_t pop_data,
    output logic                 pop,
    output vid_pkg::pixel_t      rgb
);

    // One pixel per tick during active video
    assign pop = pixel_tick && active && !empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rgb <= '0;
        end else if (pixel_tick) begin
            rgb <= pop ? pop_data : '0;     // Black when blanked or starved
        end
    end

endmodule

`default_nettype wire

//--- src/vid_top.sv
`timescale 1ns/10ps
`default_nettype none

module vid_top (
    input  wire logic          clk,
    input  wire logic          reset_n,
    input  wire vid_pkg::bus_t bus_in,
    output vid_pkg::bus_t      bus_out,
    output vid_pkg::sync_t     sync,
    output vid_pkg::pixel_t    rgb
);

    vid_pkg::vid_cfg_t cfg;
    logic              reg_wr;
    vid_pkg::word_t    reg_addr;
    vid_pkg::word_t    reg_data;
    logic              fetch_line;
    vid_pkg::coord_t   fetch_y;
    logic              pixel_tick;
    logic              active;
    logic              push;
    vid_pkg::pixel_t   push_data;
    logic              pop;
    vid_pkg::pixel_t   pop_data;
    logic              empty;

    vid_bus_ctrl bus_ctrl_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .bus_in     (bus_in),
        .cfg        (cfg),
        .fetch_line (fetch_line),
        .fetch_y    (fetch_y),
        .bus_out    (bus_out),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .push       (push),
        .push_data  (push_data)
    );

    vid_regs regs_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .reg_wr   (reg_wr),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .cfg      (cfg)
    );

    vid_timing timing_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .cfg        (cfg),
        .sync       (sync),
        .pixel_tick (pixel_tick),
        .active     (active),
        .fetch_line (fetch_line),
        .fetch_y    (fetch_y)
    );

    pixel_fifo pixel_fifo_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .flush     (fetch_line),            // New line starts from an empty FIFO
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    pixel_out pixel_out_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .pixel_tick (pixel_tick),
        .active     (active),
        .empty      (empty),
        .pop_data   (pop_data),
        .pop        (pop),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

//--- bench/vid_properties.sv
`timescale 1ns/10ps
`default_nettype none

module vid_properties (
    input wire logic              clk,
    input wire logic              reset_n,
    input wire vid_pkg::bus_cmd_t cmd_out,
    input wire vid_pkg::bus_cmd_t cmd_in,
    input wire logic              push,
    input wire logic              full
);

    logic       burst_open;     // Request issued, beats still due
    logic [1:0] beats;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            burst_open <= 1'b0;
            beats      <= '0;
        end else if (cmd_out == vid_pkg::cmd_rd_req) begin
            burst_open <= 1'b1;
            beats      <= '0;
        end else if (burst_open && cmd_in == vid_pkg::cmd_rd_data) begin
            beats <= beats + 1'b1;
            if (beats == 2'd3) begin
                burst_open <= 1'b0;
            end
        end
    end

    wr_resp_single: assert property (@(posedge clk) disable iff (!reset_n)
        cmd_out == vid_pkg::cmd_wr_resp |=> cmd_out != vid_pkg::cmd_wr_resp)
        else $error("write response held longer than one cycle");

    req_after_beats: assert property (@(posedge clk) disable iff (!reset_n)
        cmd_out == vid_pkg::cmd_rd_req |-> !burst_open)
        else $error("read request before the previous burst finished");

    no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
        push |-> !full)
        else $error("FIFO push while full");

endmodule

bind vid_bus_ctrl vid_properties bus_props_i (
    .clk     (clk),
    .reset_n (reset_n),
    .cmd_out (bus_out.cmd),
    .cmd_in  (bus_in.cmd),
    .push    (1'b0),
    .full    (1'b0)
);

bind pixel_fifo vid_properties fifo_props_i (
    .clk     (clk),
    .reset_n (reset_n),
    .cmd_out (vid_pkg::cmd_idle),
    .cmd_in  (vid_pkg::cmd_idle),
    .push    (push),
    .full    (full)
);

`default_nettype wire

//--- bench/vid_bus_tasks.svh
// Galois LFSR, one step per bit taken
function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
endfunction

// Host register write: request, wait for the response, then data
task automatic write_reg(input vid_pkg::word_t offset, input vid_pkg::word_t value);
    int n;
    @(posedge clk);
    bus_in <= '{cmd: vid_pkg::cmd_wr_req, len: 2'b00, addr_data: offset};
    @(posedge clk);
    bus_in <= '{cmd: vid_pkg::cmd_idle, len: 2'b00, addr_data: '0};
    n = 0;
    @(negedge clk);
    while (bus_out.cmd != vid_pkg::cmd_wr_resp && n < timeout_clks) begin
        @(negedge clk);
        n++;
    end
    if (n >= timeout_clks) begin
        $display("No write response for offset %0h within %0d clocks", offset, timeout_clks);
        errors++;
        test_err++;
    end
    @(posedge clk);
    bus_in <= '{cmd: vid_pkg::cmd_wr_data, len: 2'b00, addr_data: value};
    @(posedge clk);
    bus_in <= '{cmd: vid_pkg::cmd_idle, len: 2'b00, addr_data: '0};
endtask

// Memory side: four data beats with random gaps of 0 to 3 cycles between them
task automatic serve_burst(input vid_pkg::word_t addr);
    int gap;
    vid_pkg::word_t beat_addr;
    for (int b = 0; b < vid_pkg::burst_beats; b++) begin
        beat_addr = addr + vid_pkg::word_t'(4 * b);
        @(posedge clk);
        bus_in <= '{cmd: vid_pkg::cmd_rd_data, len: 2'b00,
                    addr_data: {8'h00, expected_pixel(beat_addr)}};
        if (b < vid_pkg::burst_beats - 1) begin
            gap = {lfsr_bit(), lfsr_bit()};
            repeat (gap) begin
                @(posedge clk);
                bus_in <= '{cmd: vid_pkg::cmd_idle, len: 2'b00, addr_data: '0};
            end
        end
    end
    @(posedge clk);
    bus_in <= '{cmd: vid_pkg::cmd_idle, len: 2'b00, addr_data: '0};
endtask

//--- bench/tb_vid.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vid;

    localparam int timeout_clks = 2000;
    localparam int pd       = 1;
    localparam int hsize    = 8;
    localparam int hend     = 24;
    localparam int hs_start = 12;
    localparam int hs_end   = 16;
    localparam int vsize    = 4;
    localparam int vend     = 7;
    localparam int vs_start = 5;
    localparam int vs_end   = 6;
    localparam vid_pkg::word_t base     = 32'h0001_0000;
    localparam vid_pkg::word_t line_inc = 32'h0000_0100;

    logic              clk;
    logic              reset_n;
    vid_pkg::bus_t     bus_in;
    vid_pkg::bus_t     bus_out;
    vid_pkg::sync_t    sync;
    vid_pkg::pixel_t   rgb;
    logic [31:0]       lfsr_state;
    int                errors;
    int                test_err;
    int                tests;
    int                failed_tests;
    int                req_count;
    int                fetch_err;
    int                exp_y;
    int                exp_k;
    string             cur_test;

    // Memory content as a hash of the whole word address
    function automatic vid_pkg::pixel_t expected_pixel(input vid_pkg::word_t addr);
        vid_pkg::word_t h;
        h = addr * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ addr;
        return vid_pkg::pixel_t'(h[23:0]);
    endfunction

    `include "vid_bus_tasks.svh"

    vid_top dut_i (
        .clk     (clk),
        .reset_n (reset_n),
        .bus_in  (bus_in),
        .bus_out (bus_out),
        .sync    (sync),
        .rgb     (rgb)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic sync_bit(input int which);
        case (which)
            0: return sync.hsync;
            1: return sync.hblank;
            2: return sync.vsync;
            default: return sync.vblank;
        endcase
    endfunction

    task automatic check_value(input string what, input vid_pkg::word_t exp,
                               input vid_pkg::word_t got);
        assert (exp == got) else begin
            $display("MISMATCH %s %s expected %0h actual %0h", cur_test, what, exp, got);
            errors++;
            test_err++;
        end
    endtask

    task automatic wait_level(input int which, input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (sync_bit(which) !== level && n < timeout_clks) begin
            @(negedge clk);
            n++;
        end
        if (n >= timeout_clks) begin
            $display("%s: sync bit %0d never reached %b", cur_test, which, level);
            errors++;
            test_err++;
        end
    endtask

    task automatic wait_edge(input int which, input logic level);
        wait_level(which, !level);
        wait_level(which, level);
    endtask

    // Counts clocks while the bit holds its level, from the current negedge
    task automatic level_width(input int which, input logic level, output int n);
        n = 0;
        while (sync_bit(which) === level && n < timeout_clks) begin
            n++;
            @(negedge clk);
        end
        if (n >= timeout_clks) begin
            $display("%s: sync bit %0d stuck at %b", cur_test, which, level);
            errors++;
            test_err++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err = 0;
    endtask

    task automatic end_test();
        tests++;
        if (test_err != 0) begin
            failed_tests++;
        end
        $display("test %s: %s (%0d errors)", cur_test, (test_err == 0) ? "PASS" : "FAIL",
                 test_err);
    endtask

    // Memory model with address check on every request
    initial begin
        forever begin
            @(negedge clk);
            if (bus_out.cmd == vid_pkg::cmd_rd_req) begin
                req_count++;
                assert (bus_out.len == 2'b10 &&
                        bus_out.addr_data == base + line_inc * exp_y + 16 * exp_k) else begin
                    $display("MISMATCH fetch addr expected %0h actual %0h (len %b)",
                             base + line_inc * exp_y + 16 * exp_k, bus_out.addr_data,
                             bus_out.len);
                    fetch_err++;
                    errors++;
                end
                exp_k = (exp_k + 1) % 2;
                if (exp_k == 0) begin
                    exp_y = (exp_y + 1) % vsize;
                end
                serve_burst(bus_out.addr_data);
            end
        end
    end

    initial begin
        int lo;
        int hi;
        int n;
        bus_in     = '{cmd: vid_pkg::cmd_idle, len: 2'b00, addr_data: '0};
        reset_n    = 1'b0;
        lfsr_state = 32'hb240_5e10;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        req_count = 0;
        fetch_err = 0;
        exp_y = 0;
        exp_k = 0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        begin_test("disabled_idle");
        repeat (20) begin
            @(negedge clk);
            check_value("sync", vid_pkg::word_t'(vid_pkg::sync_idle), vid_pkg::word_t'(sync));
            check_value("rgb", '0, vid_pkg::word_t'(rgb));
        end
        check_value("read requests", 0, req_count);
        end_test();

        write_reg(vid_pkg::reg_h1, (hsize << 13) | hend);
        write_reg(vid_pkg::reg_h2, (hs_start << 13) | hs_end);
        write_reg(vid_pkg::reg_v1, (vsize << 13) | vend);
        write_reg(vid_pkg::reg_v2, (vs_start << 13) | vs_end);
        write_reg(vid_pkg::reg_base, base);
        write_reg(vid_pkg::reg_lineinc, line_inc);
        write_reg(vid_pkg::reg_cr, (pd << 4) | 32'h8);   // Enable

        begin_test("timing");
        wait_edge(1, 1'b0);
        level_width(1, 1'b0, lo);
        level_width(1, 1'b1, hi);
        check_value("hblank low", hsize * (pd + 1), lo);
        check_value("line period", hend * (pd + 1), lo + hi);
        wait_edge(0, 1'b1);
        level_width(0, 1'b1, n);
        check_value("hsync high", (hs_end - hs_start) * (pd + 1), n);
        wait_edge(3, 1'b0);
        level_width(3, 1'b0, n);
        check_value("vblank low", vsize * hend * (pd + 1), n);
        wait_edge(2, 1'b1);
        level_width(2, 1'b1, n);
        check_value("vsync high", (vs_end - vs_start) * hend * (pd + 1), n);
        end_test();

        begin_test("pixel_data");
        wait_edge(3, 1'b0);
        for (int y = 0; y < vsize; y++) begin
            if (y > 0) begin
                wait_edge(1, 1'b0);
            end
            for (int x = 0; x < hsize; x++) begin
                check_value($sformatf("rgb y%0d x%0d", y, x),
                            vid_pkg::word_t'(expected_pixel(base + line_inc * y + 4 * x)),
                            vid_pkg::word_t'(rgb));
                repeat (pd + 1) @(negedge clk);
            end
            check_value("rgb blanked", '0, vid_pkg::word_t'(rgb));
        end
        end_test();

        begin_test("fetch_addr");
        assert (req_count >= 2 * vsize) else begin
            $display("fetch_addr: only %0d read requests were issued", req_count);
            errors++;
            test_err++;
        end
        test_err += fetch_err;
        end_test();

        begin_test("write_lock");
        wait_edge(3, 1'b1);
        write_reg(vid_pkg::reg_h1, (5 << 13) | hend);
        wait_edge(1, 1'b0);
        level_width(1, 1'b0, lo);
        check_value("hblank low", hsize * (pd + 1), lo);
        wait_edge(3, 1'b1);
        write_reg(vid_pkg::reg_cr, 32'h0);
        repeat (3) @(negedge clk);
        check_value("sync", vid_pkg::word_t'(vid_pkg::sync_idle), vid_pkg::word_t'(sync));
        check_value("rgb", '0, vid_pkg::word_t'(rgb));
        check_value("bus cmd", vid_pkg::cmd_idle, vid_pkg::word_t'(bus_out.cmd));
        end_test();

        $display("tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+bench
src/vid_pkg.sv
src/vid_bus_ctrl.sv
src/vid_regs.sv
src/vid_timing.sv
src/pixel_fifo.sv
src/pixel_out.sv
src/vid_top.sv
bench/vid_properties.sv
bench/tb_vid.sv
